/* common/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// register file sizing
`define ARCH_REG_NUM    32
`define PHYS_REG_NUM    48

// physical registers not mapped after reset
`define FREELIST_SIZE   (`PHYS_REG_NUM - `ARCH_REG_NUM)

// in-flight window
`define ROB_SIZE        8

// queue in front of decode
`define FETCHBUF_DEPTH  4

// queue toward the execution side
`define DISPQ_DEPTH     4

`endif

/* common/ctrl_pkg.sv */
package ctrl_pkg;

`include "ctrl_defs.svh"

    typedef logic [$clog2(`ARCH_REG_NUM)-1:0] areg_idx_t;
    typedef logic [$clog2(`PHYS_REG_NUM)-1:0] preg_idx_t;
    typedef logic [$clog2(`ROB_SIZE)-1:0]     rob_idx_t;

    // raw word from fetch
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    // architectural view after decode
    typedef struct packed {
        logic [31:0] pc;
        areg_idx_t   rd;
        areg_idx_t   rs1;
        areg_idx_t   rs2;
        logic        writes_rd;
    } dec_info_t;

    // renamed micro-op handed to dispatch
    typedef struct packed {
        logic [31:0] pc;
        rob_idx_t    rob_idx;
        preg_idx_t   prd;
        preg_idx_t   prs1;
        preg_idx_t   prs2;
        logic        writes_rd;
    } uop_t;

endpackage

/* design/inst_fifo.sv */
`timescale 1ns/10ps

module inst_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_push_vld,
    input  payload_t i_push_data,
    output logic     o_push_rdy,
    output logic     o_pop_vld,
    output payload_t o_pop_data,
    input  logic     i_pop_rdy
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign o_pop_vld  = (count != '0);
    assign o_pop_data = mem[rd_ptr];
    // full queue still takes a push while the head leaves
    assign o_push_rdy = (count != CNT_W'(DEPTH)) || i_pop_rdy;
    assign push       = i_push_vld && o_push_rdy;
    assign pop        = o_pop_vld && i_pop_rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/decode.sv */
`timescale 1ns/10ps

module decode (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_inst_vld,
    input  ctrl_pkg::fetch_entry_t i_inst,
    output logic                   o_inst_rdy,
    output logic                   o_dec_vld,
    output ctrl_pkg::dec_info_t    o_dec_info,
    input  logic                   i_dec_rdy
);
    // only register-register and register-immediate ALU ops write rd
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    ctrl_pkg::dec_info_t dec_nxt;
    logic [6:0]          opcode;
    logic                load;

    assign opcode = i_inst.inst[6:0];

    always_comb begin
        dec_nxt.pc        = i_inst.pc;
        dec_nxt.rd        = i_inst.inst[11:7];
        dec_nxt.rs1       = i_inst.inst[19:15];
        dec_nxt.rs2       = i_inst.inst[24:20];
        // x0 as destination is a discard
        dec_nxt.writes_rd = ((opcode == OPC_REG) || (opcode == OPC_IMM)) &&
                            (dec_nxt.rd != '0);
    end

    // stage refills when empty or draining
    assign o_inst_rdy = !o_dec_vld || i_dec_rdy;
    assign load       = i_inst_vld && o_inst_rdy;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_dec_vld <= 1'b0;
        end else if (o_inst_rdy) begin
            o_dec_vld <= i_inst_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_dec_info <= dec_nxt;
        end
    end

endmodule

/* rename/rename.sv */
`timescale 1ns/10ps
`include "ctrl_defs.svh"

module rename (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_dec_vld,
    input  ctrl_pkg::dec_info_t i_dec_info,
    output logic                o_dec_rdy,
    input  logic                i_rob_can_alloc,
    input  ctrl_pkg::rob_idx_t  i_rob_alloc_idx,
    output logic                o_rob_alloc_vld,
    output ctrl_pkg::areg_idx_t o_rob_alloc_areg,
    output ctrl_pkg::preg_idx_t o_rob_alloc_preg,
    output ctrl_pkg::preg_idx_t o_rob_alloc_old_preg,
    output logic                o_rob_alloc_writes_rd,
    input  logic                i_dispq_rdy,
    output logic                o_uop_vld,
    output ctrl_pkg::uop_t      o_uop,
    input  logic                i_release_vld,
    input  ctrl_pkg::preg_idx_t i_release_preg
);
    localparam int FL_SIZE  = `FREELIST_SIZE;
    localparam int FL_PTR_W = $clog2(FL_SIZE);
    localparam int FL_CNT_W = $clog2(FL_SIZE + 1);

    ctrl_pkg::preg_idx_t rat       [`ARCH_REG_NUM];
    ctrl_pkg::preg_idx_t free_list [FL_SIZE];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_CNT_W-1:0] fl_count;
    logic                accept;
    logic                take_preg;
    ctrl_pkg::preg_idx_t new_prd;

    assign o_dec_rdy = i_rob_can_alloc && i_dispq_rdy && (fl_count != '0);
    assign accept    = i_dec_vld && o_dec_rdy;
    assign take_preg = accept && i_dec_info.writes_rd;
    assign new_prd   = i_dec_info.writes_rd ? free_list[fl_head] : '0;

    // lookups see the table before this edge's update
    always_comb begin
        o_uop.pc        = i_dec_info.pc;
        o_uop.rob_idx   = i_rob_alloc_idx;
        o_uop.prd       = new_prd;
        o_uop.prs1      = rat[i_dec_info.rs1];
        o_uop.prs2      = rat[i_dec_info.rs2];
        o_uop.writes_rd = i_dec_info.writes_rd;
    end

    assign o_uop_vld             = accept;
    assign o_rob_alloc_vld       = accept;
    assign o_rob_alloc_areg      = i_dec_info.rd;
    assign o_rob_alloc_preg      = new_prd;
    assign o_rob_alloc_old_preg  = rat[i_dec_info.rd];
    assign o_rob_alloc_writes_rd = i_dec_info.writes_rd;

    // identity map out of reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `ARCH_REG_NUM; i++) begin
                rat[i] <= ctrl_pkg::preg_idx_t'(i);
            end
        end else if (take_preg) begin
            rat[i_dec_info.rd] <= new_prd;
        end
    end

    // free list starts full with the unmapped registers, ascending
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < FL_SIZE; i++) begin
                free_list[i] <= ctrl_pkg::preg_idx_t'(`ARCH_REG_NUM + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FL_CNT_W'(FL_SIZE);
        end else begin
            if (i_release_vld) begin
                free_list[fl_tail] <= i_release_preg;
                fl_tail            <= fl_tail + 1'b1;
            end
            if (take_preg) begin
                fl_head <= fl_head + 1'b1;
            end
            case ({i_release_vld, take_preg})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

endmodule

/* rob/rob.sv */
`timescale 1ns/10ps
`include "ctrl_defs.svh"

module rob (
    input  logic                clk,
    input  logic                i_rst_n,
    output logic                o_can_alloc,
    output ctrl_pkg::rob_idx_t  o_alloc_idx,
    input  logic                i_alloc_vld,
    input  ctrl_pkg::areg_idx_t i_alloc_areg,
    input  ctrl_pkg::preg_idx_t i_alloc_preg,
    input  ctrl_pkg::preg_idx_t i_alloc_old_preg,
    input  logic                i_alloc_writes_rd,
    input  logic [31:0]         i_alloc_pc,
    input  logic                i_wb_vld,
    input  ctrl_pkg::rob_idx_t  i_wb_rob_idx,
    output logic                o_commit_vld,
    output ctrl_pkg::rob_idx_t  o_commit_rob_idx,
    output logic [31:0]         o_commit_pc,
    output ctrl_pkg::areg_idx_t o_commit_areg,
    output ctrl_pkg::preg_idx_t o_commit_preg,
    output logic                o_release_vld,
    output ctrl_pkg::preg_idx_t o_release_preg
);
    logic [`ROB_SIZE-1:0] ent_vld;
    logic [`ROB_SIZE-1:0] ent_done;
    ctrl_pkg::areg_idx_t  ent_areg      [`ROB_SIZE];
    ctrl_pkg::preg_idx_t  ent_preg      [`ROB_SIZE];
    ctrl_pkg::preg_idx_t  ent_old_preg  [`ROB_SIZE];
    logic                 ent_writes_rd [`ROB_SIZE];
    logic [31:0]          ent_pc        [`ROB_SIZE];
    ctrl_pkg::rob_idx_t   head;
    ctrl_pkg::rob_idx_t   tail;
    logic                 alloc;
    logic                 retire;

    // full when the tail slot is still occupied
    assign o_can_alloc = !ent_vld[tail];
    assign o_alloc_idx = tail;
    assign alloc       = i_alloc_vld && o_can_alloc;
    assign retire      = ent_vld[head] && ent_done[head];

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_areg[tail]      <= i_alloc_areg;
            ent_preg[tail]      <= i_alloc_preg;
            ent_old_preg[tail]  <= i_alloc_old_preg;
            ent_writes_rd[tail] <= i_alloc_writes_rd;
            ent_pc[tail]        <= i_alloc_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ent_vld       <= '0;
            ent_done      <= '0;
            head          <= '0;
            tail          <= '0;
            o_commit_vld  <= 1'b0;
            o_release_vld <= 1'b0;
        end else begin
            if (alloc) begin
                ent_vld[tail]  <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (i_wb_vld) begin
                ent_done[i_wb_rob_idx] <= 1'b1;
            end
            if (retire) begin
                ent_vld[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            o_commit_vld  <= retire;
            // old mapping goes back in step with the commit pulse
            o_release_vld <= retire && ent_writes_rd[head];
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            o_commit_rob_idx <= head;
            o_commit_pc      <= ent_pc[head];
            o_commit_areg    <= ent_areg[head];
            o_commit_preg    <= ent_preg[head];
            o_release_preg   <= ent_old_preg[head];
        end
    end

endmodule

/* design/ctrl_block.sv */
`timescale 1ns/10ps
`include "ctrl_defs.svh"

// fetch buffer -> decode -> rename -> dispatch queue, rob alongside
module ctrl_block (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_fetch_vld,
    input  ctrl_pkg::fetch_entry_t i_fetch_entry,
    output logic                   o_fetch_rdy,
    output logic                   o_disp_vld,
    output ctrl_pkg::uop_t         o_disp_uop,
    input  logic                   i_disp_rdy,
    input  logic                   i_wb_vld,
    input  ctrl_pkg::rob_idx_t     i_wb_rob_idx,
    output logic                   o_commit_vld,
    output ctrl_pkg::rob_idx_t     o_commit_rob_idx,
    output logic [31:0]            o_commit_pc,
    output ctrl_pkg::areg_idx_t    o_commit_areg,
    output ctrl_pkg::preg_idx_t    o_commit_preg
);
    logic                   buf_vld;
    ctrl_pkg::fetch_entry_t buf_entry;
    logic                   dec_in_rdy;
    logic                   dec_vld;
    ctrl_pkg::dec_info_t    dec_info;
    logic                   ren_rdy;
    logic                   rob_can_alloc;
    ctrl_pkg::rob_idx_t     rob_alloc_idx;
    logic                   alloc_vld;
    ctrl_pkg::areg_idx_t    alloc_areg;
    ctrl_pkg::preg_idx_t    alloc_preg;
    ctrl_pkg::preg_idx_t    alloc_old_preg;
    logic                   alloc_writes_rd;
    logic                   dispq_rdy;
    logic                   uop_vld;
    ctrl_pkg::uop_t         uop;
    logic                   release_vld;
    ctrl_pkg::preg_idx_t    release_preg;

    inst_fifo #(
        .payload_t ( ctrl_pkg::fetch_entry_t ),
        .DEPTH     ( `FETCHBUF_DEPTH         )
    ) fetch_buf (
        .clk         ( clk           ),
        .i_rst_n     ( i_rst_n       ),
        .i_push_vld  ( i_fetch_vld   ),
        .i_push_data ( i_fetch_entry ),
        .o_push_rdy  ( o_fetch_rdy   ),
        .o_pop_vld   ( buf_vld       ),
        .o_pop_data  ( buf_entry     ),
        .i_pop_rdy   ( dec_in_rdy    )
    );

    decode u_decode (
        .clk        ( clk        ),
        .i_rst_n    ( i_rst_n    ),
        .i_inst_vld ( buf_vld    ),
        .i_inst     ( buf_entry  ),
        .o_inst_rdy ( dec_in_rdy ),
        .o_dec_vld  ( dec_vld    ),
        .o_dec_info ( dec_info   ),
        .i_dec_rdy  ( ren_rdy    )
    );

    rename u_rename (
        .clk                   ( clk             ),
        .i_rst_n               ( i_rst_n         ),
        .i_dec_vld             ( dec_vld         ),
        .i_dec_info            ( dec_info        ),
        .o_dec_rdy             ( ren_rdy         ),
        .i_rob_can_alloc       ( rob_can_alloc   ),
        .i_rob_alloc_idx       ( rob_alloc_idx   ),
        .o_rob_alloc_vld       ( alloc_vld       ),
        .o_rob_alloc_areg      ( alloc_areg      ),
        .o_rob_alloc_preg      ( alloc_preg      ),
        .o_rob_alloc_old_preg  ( alloc_old_preg  ),
        .o_rob_alloc_writes_rd ( alloc_writes_rd ),
        .i_dispq_rdy           ( dispq_rdy       ),
        .o_uop_vld             ( uop_vld         ),
        .o_uop                 ( uop             ),
        .i_release_vld         ( release_vld     ),
        .i_release_preg        ( release_preg    )
    );

    inst_fifo #(
        .payload_t ( ctrl_pkg::uop_t ),
        .DEPTH     ( `DISPQ_DEPTH    )
    ) disp_q (
        .clk         ( clk        ),
        .i_rst_n     ( i_rst_n    ),
        .i_push_vld  ( uop_vld    ),
        .i_push_data ( uop        ),
        .o_push_rdy  ( dispq_rdy  ),
        .o_pop_vld   ( o_disp_vld ),
        .o_pop_data  ( o_disp_uop ),
        .i_pop_rdy   ( i_disp_rdy )
    );

    // pc rides along from the renamed uop
    rob u_rob (
        .clk               ( clk              ),
        .i_rst_n           ( i_rst_n          ),
        .o_can_alloc       ( rob_can_alloc    ),
        .o_alloc_idx       ( rob_alloc_idx    ),
        .i_alloc_vld       ( alloc_vld        ),
        .i_alloc_areg      ( alloc_areg       ),
        .i_alloc_preg      ( alloc_preg       ),
        .i_alloc_old_preg  ( alloc_old_preg   ),
        .i_alloc_writes_rd ( alloc_writes_rd  ),
        .i_alloc_pc        ( uop.pc           ),
        .i_wb_vld          ( i_wb_vld         ),
        .i_wb_rob_idx      ( i_wb_rob_idx     ),
        .o_commit_vld      ( o_commit_vld     ),
        .o_commit_rob_idx  ( o_commit_rob_idx ),
        .o_commit_pc       ( o_commit_pc      ),
        .o_commit_areg     ( o_commit_areg    ),
        .o_commit_preg     ( o_commit_preg    ),
        .o_release_vld     ( release_vld      ),
        .o_release_preg    ( release_preg     )
    );

endmodule

/* test/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int HALF_PERIOD = 20,
    parameter int RST_CYCLES  = 10
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // release lands on a falling edge like every other input
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

/* test/ctrl_block_chk.sv */
`timescale 1ns/10ps

module ctrl_block_chk (
    input logic                   clk,
    input logic                   i_rst_n,
    input logic                   i_fetch_vld,
    input ctrl_pkg::fetch_entry_t i_fetch_entry,
    input logic                   i_fetch_rdy,
    input logic                   i_disp_vld,
    input ctrl_pkg::uop_t         i_disp_uop,
    input logic                   i_disp_rdy,
    input logic                   i_commit_vld,
    input ctrl_pkg::rob_idx_t     i_commit_rob_idx
);
    int                 fail_fetch_hold = 0;
    int                 fail_disp_hold  = 0;
    int                 fail_reset      = 0;
    int                 fail_order      = 0;
    ctrl_pkg::rob_idx_t last_idx;
    logic               seen_commit;

    // index of the previous commit
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            seen_commit <= 1'b0;
        end else if (i_commit_vld) begin
            seen_commit <= 1'b1;
            last_idx    <= i_commit_rob_idx;
        end
    end

    fetch_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_fetch_vld && !i_fetch_rdy |=> i_fetch_vld && $stable(i_fetch_entry))
        else begin
            fail_fetch_hold++;
            $error("fetch valid dropped or payload changed before ready");
        end

    disp_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_disp_vld && !i_disp_rdy |=> i_disp_vld && $stable(i_disp_uop))
        else begin
            fail_disp_hold++;
            $error("dispatch valid dropped or uop changed before ready");
        end

    reset_quiet: assert property (@(posedge clk) !i_rst_n |=> !i_commit_vld)
        else begin
            fail_reset++;
            $error("commit pulse while reset is held");
        end

    // wraps at the 3-bit index width
    commit_order: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_commit_vld && seen_commit |->
            i_commit_rob_idx == ctrl_pkg::rob_idx_t'(last_idx + 1'b1))
        else begin
            fail_order++;
            $error("commit rob index skipped or repeated");
        end

endmodule

/* test/tb_ctrl_block.sv */
`timescale 1ns/10ps
`include "ctrl_defs.svh"

module tb_ctrl_block;
    localparam int         N_ROWS    = 24;
    localparam int         MAX_CYCLE = 3000;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic                   clk;
    logic                   rst_n;
    logic                   fetch_vld;
    ctrl_pkg::fetch_entry_t fetch_entry;
    logic                   fetch_rdy;
    logic                   disp_vld;
    ctrl_pkg::uop_t         disp_uop;
    logic                   disp_rdy;
    logic                   wb_vld;
    ctrl_pkg::rob_idx_t     wb_rob_idx;
    logic                   commit_vld;
    ctrl_pkg::rob_idx_t     commit_rob_idx;
    logic [31:0]            commit_pc;
    ctrl_pkg::areg_idx_t    commit_areg;
    ctrl_pkg::preg_idx_t    commit_preg;

    // stimulus table
    logic [31:0] row_pc    [N_ROWS];
    logic [31:0] row_inst  [N_ROWS];
    int          row_stall [N_ROWS];
    int          row_delay [N_ROWS];
    logic        row_wr    [N_ROWS];

    // reference rename state and predicted commits
    ctrl_pkg::preg_idx_t model_rat  [`ARCH_REG_NUM];
    ctrl_pkg::preg_idx_t model_free [$];
    logic [31:0]         exp_pc     [$];
    ctrl_pkg::areg_idx_t exp_areg   [$];
    ctrl_pkg::preg_idx_t exp_preg   [$];
    ctrl_pkg::preg_idx_t exp_old    [$];
    logic                exp_wr     [$];

    // dispatched but not yet written back
    ctrl_pkg::rob_idx_t pend_idx  [$];
    int                 pend_time [$];

    int   n_checks;
    int   n_errors;
    int   fetch_idx;
    int   disp_idx;
    int   n_commit;
    int   cycle;
    int   stall_left;
    int   chk_fails;
    logic saw_fetch_full;
    logic saw_rob_full;
    logic rst_ok;

    tb_clkgen clkgen0 (
        .o_clk   ( clk   ),
        .o_rst_n ( rst_n )
    );

    ctrl_block dut0 (
        .clk              ( clk            ),
        .i_rst_n          ( rst_n          ),
        .i_fetch_vld      ( fetch_vld      ),
        .i_fetch_entry    ( fetch_entry    ),
        .o_fetch_rdy      ( fetch_rdy      ),
        .o_disp_vld       ( disp_vld       ),
        .o_disp_uop       ( disp_uop       ),
        .i_disp_rdy       ( disp_rdy       ),
        .i_wb_vld         ( wb_vld         ),
        .i_wb_rob_idx     ( wb_rob_idx     ),
        .o_commit_vld     ( commit_vld     ),
        .o_commit_rob_idx ( commit_rob_idx ),
        .o_commit_pc      ( commit_pc      ),
        .o_commit_areg    ( commit_areg    ),
        .o_commit_preg    ( commit_preg    )
    );

    bind ctrl_block ctrl_block_chk chk0 (
        .clk              ( clk              ),
        .i_rst_n          ( i_rst_n          ),
        .i_fetch_vld      ( i_fetch_vld      ),
        .i_fetch_entry    ( i_fetch_entry    ),
        .i_fetch_rdy      ( o_fetch_rdy      ),
        .i_disp_vld       ( o_disp_vld       ),
        .i_disp_uop       ( o_disp_uop       ),
        .i_disp_rdy       ( i_disp_rdy       ),
        .i_commit_vld     ( o_commit_vld     ),
        .i_commit_rob_idx ( o_commit_rob_idx )
    );

    function automatic logic [31:0] encode(logic [6:0] opc, int rd, int rs1, int rs2);
        return {7'b0000000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), opc};
    endfunction

    // ALU ops with a nonzero rd write the register file
    function automatic logic model_writes(logic [31:0] inst);
        return ((inst[6:0] == 7'b0110011) || (inst[6:0] == 7'b0010011)) &&
               (inst[11:7] != 5'd0);
    endfunction

    task automatic add_row(int i, logic [31:0] pc, logic [31:0] inst, int stall, int delay,
                           logic wr);
        row_pc[i]    = pc;
        row_inst[i]  = inst;
        row_stall[i] = stall;
        row_delay[i] = delay;
        row_wr[i]    = wr;
    endtask

    task automatic load_table();
        add_row(0,  32'h0000_1000, encode(OP_REG,    1,  2,  3),  0,  2, 1'b1);
        add_row(1,  32'h0000_1004, encode(OP_IMM,    2,  1,  0),  0,  1, 1'b1);
        add_row(2,  32'h0000_1008, encode(OP_REG,    3,  1,  2), 12,  4, 1'b1);
        add_row(3,  32'h0000_100c, encode(OP_STORE,  5,  3,  2),  0,  1, 1'b0);
        add_row(4,  32'h0000_1010, encode(OP_REG,    1,  1,  3),  0,  3, 1'b1);
        add_row(5,  32'h0000_1014, encode(OP_IMM,    0,  4,  0),  0,  2, 1'b0);
        add_row(6,  32'h0000_1018, encode(OP_REG,    4,  1,  1),  1,  1, 1'b1);
        add_row(7,  32'h0000_101c, encode(OP_LOAD,   6,  4,  0),  0,  2, 1'b0);
        // rows 8 to 15 hold back their writebacks until the rob is full
        add_row(8,  32'h0000_1020, encode(OP_REG,    5,  4,  3),  0, 40, 1'b1);
        add_row(9,  32'h0000_1024, encode(OP_IMM,    6,  5,  0),  0, 39, 1'b1);
        add_row(10, 32'h0000_1028, encode(OP_REG,    7,  6,  5),  0, 38, 1'b1);
        add_row(11, 32'h0000_102c, encode(OP_REG,    1,  7,  1),  0, 37, 1'b1);
        add_row(12, 32'h0000_1030, encode(OP_IMM,    2,  2,  0),  0, 36, 1'b1);
        add_row(13, 32'h0000_1034, encode(OP_REG,    0,  3,  4),  0, 35, 1'b0);
        add_row(14, 32'h0000_1038, encode(OP_REG,    3,  1,  2),  0, 34, 1'b1);
        add_row(15, 32'h0000_103c, encode(OP_IMM,    4,  3,  0),  0, 33, 1'b1);
        add_row(16, 32'h0000_1040, encode(OP_REG,    8,  4,  4),  0,  1, 1'b1);
        add_row(17, 32'h0000_1044, encode(OP_BRANCH, 9,  8,  1),  0,  2, 1'b0);
        add_row(18, 32'h0000_1048, encode(OP_REG,    8,  8,  2), 10,  3, 1'b1);
        add_row(19, 32'h0000_104c, encode(OP_IMM,    9,  8,  0),  0,  1, 1'b1);
        add_row(20, 32'h0000_1050, encode(OP_REG,   10,  9,  8),  0,  2, 1'b1);
        add_row(21, 32'h0000_1054, encode(OP_IMM,    1, 10,  0),  0,  1, 1'b1);
        add_row(22, 32'h0000_1058, encode(OP_REG,    2,  1, 10),  0,  3, 1'b1);
        add_row(23, 32'h0000_105c, encode(OP_REG,    3,  2,  1),  0,  1, 1'b1);
    endtask

    task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        assert (got == exp) else begin
            n_errors++;
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic check_idle(string when);
        n_checks++;
        assert (!disp_vld && !commit_vld && fetch_rdy) else begin
            n_errors++;
            $display("Error at %0t: outputs not idle %s (disp %b commit %b fetch_rdy %b)",
                     $time, when, disp_vld, commit_vld, fetch_rdy);
        end
    endtask

    task automatic check_dispatch();
        logic [31:0]         inst;
        ctrl_pkg::areg_idx_t rd;
        ctrl_pkg::preg_idx_t prd;
        logic                wr;
        if (disp_idx >= N_ROWS) begin
            n_errors++;
            $display("an extra uop was dispatched at %0t after the last instruction", $time);
        end else begin
            inst = row_inst[disp_idx];
            rd   = inst[11:7];
            wr   = model_writes(inst);
            prd  = '0;
            if (wr && model_free.size() == 0) begin
                n_errors++;
                $display("reference free list ran empty at %0t", $time);
            end else if (wr) begin
                prd = model_free.pop_front();
            end
            check_eq("uop pc", disp_uop.pc, row_pc[disp_idx]);
            check_eq("uop writes_rd", 32'(disp_uop.writes_rd), 32'(row_wr[disp_idx]));
            check_eq("uop rob_idx", 32'(disp_uop.rob_idx), disp_idx % `ROB_SIZE);
            check_eq("uop prs1", 32'(disp_uop.prs1), 32'(model_rat[inst[19:15]]));
            check_eq("uop prs2", 32'(disp_uop.prs2), 32'(model_rat[inst[24:20]]));
            check_eq("uop prd", 32'(disp_uop.prd), 32'(prd));
            exp_pc.push_back(row_pc[disp_idx]);
            exp_areg.push_back(rd);
            exp_preg.push_back(prd);
            exp_old.push_back(model_rat[rd]);
            exp_wr.push_back(wr);
            if (wr) begin
                model_rat[rd] = prd;
            end
            pend_idx.push_back(disp_uop.rob_idx);
            pend_time.push_back(cycle + row_delay[disp_idx]);
        end
        disp_idx++;
        if (disp_idx < N_ROWS) begin
            stall_left = row_stall[disp_idx];
        end
    endtask

    task automatic check_commit();
        if (exp_pc.size() == 0) begin
            n_errors++;
            $display("a commit came at %0t with no instruction in flight", $time);
        end else begin
            check_eq("commit rob_idx", 32'(commit_rob_idx), n_commit % `ROB_SIZE);
            check_eq("commit pc", commit_pc, exp_pc[0]);
            check_eq("commit areg", 32'(commit_areg), 32'(exp_areg[0]));
            check_eq("commit preg", 32'(commit_preg), 32'(exp_preg[0]));
            // old mapping goes to the tail of the free list
            if (exp_wr[0]) begin
                model_free.push_back(exp_old[0]);
            end
            exp_pc.delete(0);
            exp_areg.delete(0);
            exp_preg.delete(0);
            exp_old.delete(0);
            exp_wr.delete(0);
        end
        n_commit++;
    endtask

    task automatic drive_inputs();
        int n_ripe;
        int pick;
        fetch_vld = (fetch_idx < N_ROWS);
        if (fetch_idx < N_ROWS) begin
            fetch_entry.pc   = row_pc[fetch_idx];
            fetch_entry.inst = row_inst[fetch_idx];
        end
        if (disp_vld && stall_left > 0) begin
            disp_rdy = 1'b0;
            stall_left--;
        end else begin
            disp_rdy = 1'b1;
        end
        // one writeback per cycle, random among the ripe entries
        wb_vld = 1'b0;
        n_ripe = 0;
        for (int i = 0; i < pend_time.size(); i++) begin
            if (pend_time[i] <= cycle) begin
                n_ripe++;
            end
        end
        if (n_ripe > 0) begin
            pick = $urandom % n_ripe;
            for (int i = 0; i < pend_time.size(); i++) begin
                if (pend_time[i] <= cycle && pick == 0) begin
                    wb_vld     = 1'b1;
                    wb_rob_idx = pend_idx[i];
                    pend_idx.delete(i);
                    pend_time.delete(i);
                    break;
                end else if (pend_time[i] <= cycle) begin
                    pick--;
                end
            end
        end
    endtask

    task automatic sample_outputs();
        int pending;
        pending = pend_idx.size() + (wb_vld ? 1 : 0);
        if (fetch_vld && fetch_rdy) begin
            fetch_idx++;
        end
        if (!fetch_rdy) begin
            saw_fetch_full = 1'b1;
        end
        // every rob entry waits on a writeback
        if (pending == `ROB_SIZE) begin
            saw_rob_full = 1'b1;
            n_checks++;
            assert (!disp_vld) else begin
                n_errors++;
                $display("Error at %0t: uop dispatched while the rob is full", $time);
            end
        end
        if (commit_vld) begin
            check_commit();
        end
        n_checks++;
        assert (disp_idx - n_commit <= `ROB_SIZE) else begin
            n_errors++;
            $display("Error at %0t: %0d uops in flight past the rob size", $time,
                     disp_idx - n_commit);
        end
        if (disp_vld && disp_rdy) begin
            check_dispatch();
        end
    endtask

    initial begin
        void'($urandom(32'h6682));
        fetch_vld      = 1'b0;
        fetch_entry    = '0;
        disp_rdy       = 1'b0;
        wb_vld         = 1'b0;
        wb_rob_idx     = '0;
        n_checks       = 0;
        n_errors       = 0;
        fetch_idx      = 0;
        disp_idx       = 0;
        n_commit       = 0;
        cycle          = 0;
        saw_fetch_full = 1'b0;
        saw_rob_full   = 1'b0;
        rst_ok         = 1'b0;
        load_table();
        stall_left = row_stall[0];
        for (int r = 0; r < `ARCH_REG_NUM; r++) begin
            model_rat[r] = ctrl_pkg::preg_idx_t'(r);
        end
        for (int p = `ARCH_REG_NUM; p < `PHYS_REG_NUM; p++) begin
            model_free.push_back(ctrl_pkg::preg_idx_t'(p));
        end

        for (int i = 0; i < 40 && !rst_ok; i++) begin
            @(negedge clk);
            #1;
            if (rst_n) begin
                rst_ok = 1'b1;
            end else begin
                check_idle("during reset");
            end
        end

        if (!rst_ok) begin
            n_errors++;
            $display("reset was never released");
        end else begin
            check_idle("at reset release");
            @(negedge clk);
            #1;
            check_idle("in the first cycle after reset");
            while (n_commit < N_ROWS && cycle < MAX_CYCLE) begin
                @(negedge clk);
                drive_inputs();
                #5;
                sample_outputs();
                cycle++;
            end
            if (n_commit < N_ROWS) begin
                n_errors++;
                $display("timed out after %0d cycles with %0d of %0d instructions committed",
                         cycle, n_commit, N_ROWS);
            end
            check_eq("dispatched uop count", disp_idx, N_ROWS);
            n_checks++;
            assert (saw_fetch_full) else begin
                n_errors++;
                $display("the fetch buffer never filled under dispatch stalls");
            end
            n_checks++;
            assert (saw_rob_full) else begin
                n_errors++;
                $display("the rob never filled while writebacks were held back");
            end
        end

        chk_fails = dut0.chk0.fail_fetch_hold + dut0.chk0.fail_disp_hold +
                    dut0.chk0.fail_reset + dut0.chk0.fail_order;
        n_checks++;
        assert (chk_fails == 0) else begin
            n_errors++;
            $display("%0d bound assertion failures", chk_fails);
        end

        $display("checks %0d errors %0d commits %0d", n_checks, n_errors, n_commit);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+common
common/ctrl_pkg.sv
design/inst_fifo.sv
design/decode.sv
rename/rename.sv
rob/rob.sv
design/ctrl_block.sv
test/tb_clkgen.sv
test/ctrl_block_chk.sv
test/tb_ctrl_block.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ctrl_block -f filelist.f -o sim_tb

out=$(./obj_dir/sim_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "all tests passed"
